// File: cluster_periph.f
+incdir+include
logic/periph_bus_pkg.sv
logic/event_unit_pkg.sv
logic/periph_bus_if.sv
logic/periph_addr_demux.sv
logic/core_event_slice.sv
logic/cluster_timer.sv
logic/periph_resp_mux.sv
logic/cluster_periph_top.sv
verif/cluster_periph_tb.sv

// File: include/cluster_periph_defs.svh
/*
 * Global sizes and address decode fields of the cluster peripheral block.
 * Included by every package and module that needs a core count, an event
 * count or a bus field bound.
 */

`ifndef CLUSTER_PERIPH_DEFS_SVH
`define CLUSTER_PERIPH_DEFS_SVH

// Cores and per-core event lines
`define NB_CORES 4
`define NB_EVENTS 8

// Request id carries one bit per core plus one spare initiator
`define PERIPH_ID_WIDTH (`NB_CORES + 1)

// Address decode fields
`define TGT_SEL_MSB 11
`define TGT_SEL_LSB 8
`define REG_OFF_MSB 3
`define REG_OFF_LSB 2

// Read data returned for an unmapped target
`define PERIPH_ERR_RDATA 32'hDEADB33F

`endif

// File: logic/cluster_periph_top.sv
/*
 * Cluster peripheral block. One peripheral bus port in, routed to the per-core
 * event unit slices and the cluster timer, with one merged response port.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_periph_top (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,

  // Peripheral bus from the cores
  input  wire logic                                     periph_req_i,
  input  wire periph_bus_pkg::periph_addr_t              periph_add_i,
  input  wire logic                                     periph_wen_i,
  input  wire periph_bus_pkg::periph_data_t              periph_wdata_i,
  input  wire periph_bus_pkg::periph_id_t                periph_id_i,
  output      logic                                     periph_r_valid_o,
  output      periph_bus_pkg::periph_data_t              periph_r_rdata_o,
  output      periph_bus_pkg::periph_id_t                periph_r_id_o,

  // Per-core event sources and interrupt lines
  input  wire logic [`NB_CORES-1:0]                     dma_event_i,
  input  wire logic [`NB_CORES-1:0]                     dma_irq_i,
  input  wire logic [`NB_CORES-1:0][3:0]                hwpe_events_i,
  input  wire logic [`NB_CORES-1:0]                     irq_ack_i,
  input  wire event_unit_pkg::irq_id_t [`NB_CORES-1:0]  irq_ack_id_i,
  output      logic [`NB_CORES-1:0]                     irq_req_o,
  output      event_unit_pkg::irq_id_t [`NB_CORES-1:0]  irq_id_o
);

  import periph_bus_pkg::*;

  periph_bus_if slice_bus [`NB_CORES] ();
  periph_bus_if timer_bus ();

  logic       err_r_valid;
  periph_id_t err_r_id;
  logic       timer_event;

  //**********************************************************
  // Address decode
  //**********************************************************
  periph_addr_demux u_demux (
    .clk_i         ( clk_i          ),
    .reset_i       ( reset_i        ),
    .req_i         ( periph_req_i   ),
    .add_i         ( periph_add_i   ),
    .wen_i         ( periph_wen_i   ),
    .wdata_i       ( periph_wdata_i ),
    .id_i          ( periph_id_i    ),
    .slice_bus     ( slice_bus      ),
    .timer_bus     ( timer_bus      ),
    .err_r_valid_o ( err_r_valid    ),
    .err_r_id_o    ( err_r_id       )
  );

  //**********************************************************
  // Event unit slices, one per core
  //**********************************************************
  for (genvar g = 0; g < `NB_CORES; g++) begin : gen_slice
    core_event_slice u_slice (
      .clk_i         ( clk_i            ),
      .reset_i       ( reset_i          ),
      .bus           ( slice_bus[g]     ),
      .dma_event_i   ( dma_event_i[g]   ),
      .dma_irq_i     ( dma_irq_i[g]     ),
      .timer_event_i ( timer_event      ),
      .acc_events_i  ( hwpe_events_i[g] ),
      .irq_ack_i     ( irq_ack_i[g]     ),
      .irq_ack_id_i  ( irq_ack_id_i[g]  ),
      .irq_req_o     ( irq_req_o[g]     ),
      .irq_id_o      ( irq_id_o[g]      )
    );
  end

  //**********************************************************
  // Timer and response path
  //**********************************************************
  cluster_timer u_timer (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .bus     ( timer_bus   ),
    .event_o ( timer_event )
  );

  periph_resp_mux u_resp_mux (
    .slice_bus     ( slice_bus        ),
    .timer_bus     ( timer_bus        ),
    .err_r_valid_i ( err_r_valid      ),
    .err_r_id_i    ( err_r_id         ),
    .r_valid_o     ( periph_r_valid_o ),
    .r_rdata_o     ( periph_r_rdata_o ),
    .r_id_o        ( periph_r_id_o    )
  );

endmodule

`default_nettype wire

// File: logic/cluster_timer.sv
/*
 * Cluster timer. A free running counter that wraps at the compare value and
 * sends a one-cycle event to every core slice at each wrap.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_timer (
  input  wire logic    clk_i,
  input  wire logic    reset_i,
  periph_bus_if.target bus,
  output      logic    event_o
);

  import periph_bus_pkg::*;
  import event_unit_pkg::*;

  logic         enable_q;
  periph_data_t cnt_q;
  periph_data_t cmp_q;
  tmr_reg_e     reg_off;
  logic         wr_en;
  logic         cnt_wr;
  logic         match;
  periph_data_t rd_data;

  assign reg_off = tmr_reg_e'(bus.add[`REG_OFF_MSB:`REG_OFF_LSB]);
  assign wr_en   = bus.req && !bus.wen;
  assign cnt_wr  = wr_en && (reg_off == TMR_CNT);
  assign match   = enable_q && (cnt_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      cnt_q    <= '0;
      cmp_q    <= '0;
      event_o  <= 1'b0;
    end else begin
      if (wr_en && (reg_off == TMR_CFG)) begin
        enable_q <= bus.wdata[0];
      end
      if (wr_en && (reg_off == TMR_CMP)) begin
        cmp_q <= bus.wdata;
      end
      // Software load beats counting and wrapping
      if (cnt_wr) begin
        cnt_q <= bus.wdata;
      end else if (match) begin
        cnt_q <= '0;
      end else if (enable_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
      event_o <= match && !cnt_wr;
    end
  end

  always_comb begin
    case (reg_off)
      TMR_CFG: rd_data = {31'd0, enable_q};
      TMR_CNT: rd_data = cnt_q;
      TMR_CMP: rd_data = cmp_q;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    bus.r_rdata <= bus.wen ? rd_data : '0;
    bus.r_id    <= bus.id;
  end

  // The event never lasts longer than one cycle
  assert property (@(posedge clk_i) disable iff (reset_i) event_o |=> !event_o);

endmodule

`default_nettype wire

// File: logic/core_event_slice.sv
/*
 * Event unit of one core. Buffers the incoming events, masks them and raises
 * an interrupt with the lowest pending index. The core clears the event with
 * an acknowledge or through the EU_BUFFER register.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module core_event_slice (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  periph_bus_if.target                 bus,
  input  wire logic                    dma_event_i,
  input  wire logic                    dma_irq_i,
  input  wire logic                    timer_event_i,
  input  wire logic [3:0]              acc_events_i,
  input  wire logic                    irq_ack_i,
  input  wire event_unit_pkg::irq_id_t irq_ack_id_i,
  output      logic                    irq_req_o,
  output      event_unit_pkg::irq_id_t irq_id_o
);

  import periph_bus_pkg::*;
  import event_unit_pkg::*;

  logic [`NB_EVENTS-1:0] mask_q;
  logic [`NB_EVENTS-1:0] buf_q;
  logic [`NB_EVENTS-1:0] evt_set;
  logic [`NB_EVENTS-1:0] evt_clr;
  logic [`NB_EVENTS-1:0] pending;
  eu_reg_e               reg_off;
  logic                  wr_en;
  periph_data_t          rd_data;

  assign reg_off = eu_reg_e'(bus.add[`REG_OFF_MSB:`REG_OFF_LSB]);
  assign wr_en   = bus.req && !bus.wen;

  //**********************************************************
  // Event collection
  //**********************************************************
  always_comb begin
    evt_set                 = '0;
    evt_set[EVT_DMA]        = dma_event_i;
    evt_set[EVT_DMA_IRQ]    = dma_irq_i;
    evt_set[EVT_TIMER]      = timer_event_i;
    evt_set[EVT_ACC0 +: 4]  = acc_events_i;
    evt_set[EVT_SW]         = wr_en && (reg_off == EU_SW_EVT);
  end

  // Acknowledge and write-one-to-clear both remove bits
  always_comb begin
    evt_clr = '0;
    if (irq_ack_i) begin
      evt_clr[irq_ack_id_i] = 1'b1;
    end
    if (wr_en && (reg_off == EU_BUFFER)) begin
      evt_clr = evt_clr | bus.wdata[`NB_EVENTS-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
      buf_q  <= '0;
    end else begin
      // A new event wins over a clear of the same bit
      buf_q <= (buf_q & ~evt_clr) | evt_set;
      if (wr_en && (reg_off == EU_MASK)) begin
        mask_q <= bus.wdata[`NB_EVENTS-1:0];
      end
    end
  end

  //**********************************************************
  // Interrupt request
  //**********************************************************
  assign pending   = buf_q & mask_q;
  assign irq_req_o = |pending;

  always_comb begin
    irq_id_o = '0;
    for (int i = `NB_EVENTS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  //**********************************************************
  // Register reads and response
  //**********************************************************
  always_comb begin
    case (reg_off)
      EU_MASK:   rd_data = periph_data_t'(mask_q);
      EU_BUFFER: rd_data = periph_data_t'(buf_q);
      EU_IRQ_ID: rd_data = periph_data_t'(irq_id_o);
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= bus.req;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    bus.r_rdata <= bus.wen ? rd_data : '0;
    bus.r_id    <= bus.id;
  end

  // The core only acknowledges an interrupt that is being requested
  assert property (@(posedge clk_i) disable iff (reset_i) irq_ack_i |-> irq_req_o);

endmodule

`default_nettype wire

// File: logic/event_unit_pkg.sv
/*
 * Event line numbering and register maps of the event unit slice and the
 * cluster timer. Imported by the slice, the timer and the top level.
 */

`default_nettype none

`include "cluster_periph_defs.svh"

package event_unit_pkg;

  // Lower index means higher interrupt priority
  typedef enum logic [2:0] {
    EVT_DMA     = 3'd0,
    EVT_DMA_IRQ = 3'd1,
    EVT_TIMER   = 3'd2,
    EVT_ACC0    = 3'd3,
    EVT_ACC1    = 3'd4,
    EVT_ACC2    = 3'd5,
    EVT_ACC3    = 3'd6,
    EVT_SW      = 3'd7
  } evt_idx_e;

  // Slice register offsets, address bits 3:2
  typedef enum logic [1:0] {
    EU_MASK   = 2'd0,
    EU_BUFFER = 2'd1,
    EU_SW_EVT = 2'd2,
    EU_IRQ_ID = 2'd3
  } eu_reg_e;

  // Timer register offsets
  typedef enum logic [1:0] {
    TMR_CFG = 2'd0,
    TMR_CNT = 2'd1,
    TMR_CMP = 2'd2
  } tmr_reg_e;

  typedef logic [$clog2(`NB_EVENTS)-1:0] irq_id_t;

endpackage

`default_nettype wire

// File: logic/periph_addr_demux.sv
/*
 * Routes each peripheral bus request to one event unit slice or to the timer
 * by the target select field. Unmapped selects get an error response here,
 * one cycle later, like any other target.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module periph_addr_demux (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire logic                        req_i,
  input  wire periph_bus_pkg::periph_addr_t add_i,
  input  wire logic                        wen_i,
  input  wire periph_bus_pkg::periph_data_t wdata_i,
  input  wire periph_bus_pkg::periph_id_t   id_i,
  periph_bus_if.initiator                  slice_bus [`NB_CORES],
  periph_bus_if.initiator                  timer_bus,
  output      logic                        err_r_valid_o,
  output      periph_bus_pkg::periph_id_t   err_r_id_o
);

  import periph_bus_pkg::*;

  tgt_sel_e   tgt_sel;
  logic [3:0] slice_idx;
  logic       timer_hit;
  logic       slice_hit;

  assign tgt_sel   = tgt_sel_e'(add_i[`TGT_SEL_MSB:`TGT_SEL_LSB]);
  assign slice_idx = tgt_sel - TGT_CORE0;
  assign timer_hit = (tgt_sel == TGT_TIMER);
  assign slice_hit = !timer_hit && (slice_idx < `NB_CORES);

  //**********************************************************
  // Request steering
  //**********************************************************
  for (genvar g = 0; g < `NB_CORES; g++) begin : gen_slice_req
    assign slice_bus[g].req   = req_i && slice_hit && (slice_idx == 4'(g));
    assign slice_bus[g].add   = add_i;
    assign slice_bus[g].wen   = wen_i;
    assign slice_bus[g].wdata = wdata_i;
    assign slice_bus[g].id    = id_i;
  end

  assign timer_bus.req   = req_i && timer_hit;
  assign timer_bus.add   = add_i;
  assign timer_bus.wen   = wen_i;
  assign timer_bus.wdata = wdata_i;
  assign timer_bus.id    = id_i;

  //**********************************************************
  // Error response for unmapped targets
  //**********************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_r_valid_o <= 1'b0;
    end else begin
      err_r_valid_o <= req_i && !timer_hit && !slice_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    err_r_id_o <= id_i;
  end

endmodule

`default_nettype wire

// File: logic/periph_bus_if.sv
/*
 * Internal peripheral bus between the address demux, the targets and the
 * response mux. Requests are accepted whenever req is high, wen low is a write.
 */

`timescale 1ns/10ps
`default_nettype none

interface periph_bus_if;

  import periph_bus_pkg::*;

  logic         req;
  periph_addr_t add;
  logic         wen;
  periph_data_t wdata;
  periph_id_t   id;

  // One-cycle response, no back-pressure
  logic         r_valid;
  periph_data_t r_rdata;
  periph_id_t   r_id;

  modport initiator (output req, add, wen, wdata, id);

  modport target (
    input  req, add, wen, wdata, id,
    output r_valid, r_rdata, r_id
  );

  modport response (input r_valid, r_rdata, r_id);

endinterface

`default_nettype wire

// File: logic/periph_bus_pkg.sv
/*
 * Field types of the peripheral bus and the target select encoding.
 * Imported by the bus interface and by every module that decodes it.
 */

`default_nettype none

`include "cluster_periph_defs.svh"

package periph_bus_pkg;

  typedef logic [31:0] periph_addr_t;
  typedef logic [31:0] periph_data_t;
  typedef logic [`PERIPH_ID_WIDTH-1:0] periph_id_t;

  // Target select field, address bits 11:8
  // Slices sit at consecutive codes from TGT_CORE0, other codes are unmapped
  typedef enum logic [3:0] {
    TGT_CORE0 = 4'd0,
    TGT_TIMER = 4'd15
  } tgt_sel_e;

endpackage

`default_nettype wire

// File: logic/periph_resp_mux.sv
/*
 * Merges the one-cycle responses of the slices, the timer and the demux
 * error path onto the single response port. At most one source is valid.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module periph_resp_mux (
  periph_bus_if.response                   slice_bus [`NB_CORES],
  periph_bus_if.response                   timer_bus,
  input  wire logic                        err_r_valid_i,
  input  wire periph_bus_pkg::periph_id_t   err_r_id_i,
  output      logic                        r_valid_o,
  output      periph_bus_pkg::periph_data_t r_rdata_o,
  output      periph_bus_pkg::periph_id_t   r_id_o
);

  import periph_bus_pkg::*;

  logic [`NB_CORES-1:0] s_valid;
  periph_data_t         s_rdata [`NB_CORES];
  periph_id_t           s_id    [`NB_CORES];

  // Interface arrays need constant indices
  for (genvar g = 0; g < `NB_CORES; g++) begin : gen_flat
    assign s_valid[g] = slice_bus[g].r_valid;
    assign s_rdata[g] = slice_bus[g].r_rdata;
    assign s_id[g]    = slice_bus[g].r_id;
  end

  always_comb begin
    r_valid_o = 1'b0;
    r_rdata_o = '0;
    r_id_o    = '0;
    for (int i = 0; i < `NB_CORES; i++) begin
      if (s_valid[i]) begin
        r_valid_o = 1'b1;
        r_rdata_o = s_rdata[i];
        r_id_o    = s_id[i];
      end
    end
    if (timer_bus.r_valid) begin
      r_valid_o = 1'b1;
      r_rdata_o = timer_bus.r_rdata;
      r_id_o    = timer_bus.r_id;
    end
    if (err_r_valid_i) begin
      r_valid_o = 1'b1;
      r_rdata_o = `PERIPH_ERR_RDATA;
      r_id_o    = err_r_id_i;
    end
  end

  // One request per cycle upstream means one response per cycle here
  always_comb begin
    assert final ($onehot0({s_valid, timer_bus.r_valid, err_r_valid_i}));
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the cluster peripheral testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f cluster_periph.f \
  --top-module cluster_periph_tb \
  -o sim_cluster_periph

./obj_dir/sim_cluster_periph | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
grep -q "TEST PASSED" sim.log

// File: verif/cluster_periph_tb.sv
/*
 * Testbench for the cluster peripheral block. Drives the peripheral bus and
 * the per-core event lines with directed and LCG random stimulus, and checks
 * every cycle against a reference model of the slices and the timer.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_periph_tb;

  import periph_bus_pkg::*;
  import event_unit_pkg::*;

  localparam int RANDOM_CYCLES = 2000;
  // About 2250 cycles of tests plus margin
  localparam int MAX_CYCLES    = 3000;

  logic                              clk_i = 1'b0;
  logic                              reset_i;
  logic                              periph_req_i;
  logic [31:0]                       periph_add_i;
  logic                              periph_wen_i;
  logic [31:0]                       periph_wdata_i;
  logic [`PERIPH_ID_WIDTH-1:0]       periph_id_i;
  logic                              periph_r_valid_o;
  logic [31:0]                       periph_r_rdata_o;
  logic [`PERIPH_ID_WIDTH-1:0]       periph_r_id_o;
  logic [`NB_CORES-1:0]              dma_event_i;
  logic [`NB_CORES-1:0]              dma_irq_i;
  logic [`NB_CORES-1:0][3:0]         hwpe_events_i;
  logic [`NB_CORES-1:0]              irq_ack_i;
  logic [`NB_CORES-1:0][2:0]         irq_ack_id_i;
  logic [`NB_CORES-1:0]              irq_req_o;
  logic [`NB_CORES-1:0][2:0]         irq_id_o;

  // Reference model state
  logic [`NB_EVENTS-1:0]             m_mask [`NB_CORES];
  logic [`NB_EVENTS-1:0]             m_buf  [`NB_CORES];
  logic                              m_en;
  logic                              m_evt;
  logic [31:0]                       m_cnt;
  logic [31:0]                       m_cmp;
  logic                              exp_rvalid;
  logic [31:0]                       exp_rdata;
  logic [`PERIPH_ID_WIDTH-1:0]       exp_rid;

  logic [31:0]                       rng_state;
  string                             test_name;
  int                                cycle_cnt = 0;

  cluster_periph_top DUT (.*);

  always #2 clk_i = ~clk_i;

  //************************************************************
  // Helpers
  //************************************************************
  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    hi = rng_state[31:16];
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {hi, rng_state[31:16]};
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand32() % 32'(n));
  endfunction

  // Highest priority is the lowest set index
  function automatic logic [2:0] lowest_pending(input logic [`NB_EVENTS-1:0] p);
    logic [2:0] idx;
    logic       found;
    idx = 3'd0;
    found = 1'b0;
    for (int i = 0; i < `NB_EVENTS; i++) begin
      if (p[i] && !found) begin
        idx = 3'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic logic [31:0] slice_read(input int c, input logic [1:0] off);
    case (off)
      EU_MASK:   return 32'(m_mask[c]);
      EU_BUFFER: return 32'(m_buf[c]);
      EU_IRQ_ID: return 32'(lowest_pending(m_buf[c] & m_mask[c]));
      default:   return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] timer_read(input logic [1:0] off);
    case (off)
      TMR_CFG: return {31'd0, m_en};
      TMR_CNT: return m_cnt;
      TMR_CMP: return m_cmp;
      default: return 32'd0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  //************************************************************
  // Reference model, checked and advanced between clock edges
  //************************************************************
  task automatic compare_outputs();
    logic [`NB_EVENTS-1:0] pend;
    check_value({test_name, " r_valid"}, 32'(exp_rvalid), 32'(periph_r_valid_o));
    if (exp_rvalid) begin
      check_value({test_name, " r_rdata"}, exp_rdata, periph_r_rdata_o);
      check_value({test_name, " r_id"}, 32'(exp_rid), 32'(periph_r_id_o));
    end
    for (int c = 0; c < `NB_CORES; c++) begin
      pend = m_buf[c] & m_mask[c];
      check_value($sformatf("%s irq_req core %0d", test_name, c),
                  32'(|pend), 32'(irq_req_o[c]));
      if (|pend) begin
        check_value($sformatf("%s irq_id core %0d", test_name, c),
                    32'(lowest_pending(pend)), 32'(irq_id_o[c]));
      end
    end
  endtask

  task automatic step_model();
    logic [3:0]            sel;
    logic [1:0]            off;
    logic                  wr;
    logic                  hit;
    logic                  match;
    logic                  cnt_wr;
    logic [`NB_EVENTS-1:0] set_v;
    logic [`NB_EVENTS-1:0] clr_v;
    sel = periph_add_i[`TGT_SEL_MSB:`TGT_SEL_LSB];
    off = periph_add_i[`REG_OFF_MSB:`REG_OFF_LSB];
    wr  = periph_req_i && !periph_wen_i;

    // Response for the request taken at the next edge, state before the update
    exp_rvalid = periph_req_i;
    exp_rid    = periph_id_i;
    if (sel < 4'(`NB_CORES)) begin
      exp_rdata = periph_wen_i ? slice_read(int'(sel), off) : 32'd0;
    end else if (sel == TGT_TIMER) begin
      exp_rdata = periph_wen_i ? timer_read(off) : 32'd0;
    end else begin
      exp_rdata = `PERIPH_ERR_RDATA;
    end

    for (int c = 0; c < `NB_CORES; c++) begin
      hit   = wr && (sel == 4'(c));
      set_v = {hit && (off == EU_SW_EVT), hwpe_events_i[c], m_evt,
               dma_irq_i[c], dma_event_i[c]};
      clr_v = '0;
      if (irq_ack_i[c]) begin
        clr_v[irq_ack_id_i[c]] = 1'b1;
      end
      if (hit && (off == EU_BUFFER)) begin
        clr_v = clr_v | periph_wdata_i[`NB_EVENTS-1:0];
      end
      // Set beats clear
      m_buf[c] = (m_buf[c] & ~clr_v) | set_v;
      if (hit && (off == EU_MASK)) begin
        m_mask[c] = periph_wdata_i[`NB_EVENTS-1:0];
      end
    end

    hit    = wr && (sel == TGT_TIMER);
    match  = m_en && (m_cnt == m_cmp);
    cnt_wr = hit && (off == TMR_CNT);
    m_evt  = match && !cnt_wr;
    if (cnt_wr) begin
      m_cnt = periph_wdata_i;
    end else if (match) begin
      m_cnt = 32'd0;
    end else if (m_en) begin
      m_cnt = m_cnt + 32'd1;
    end
    if (hit && (off == TMR_CFG)) begin
      m_en = periph_wdata_i[0];
    end
    if (hit && (off == TMR_CMP)) begin
      m_cmp = periph_wdata_i;
    end
  endtask

  always @(negedge clk_i) begin
    if (reset_i) begin
      for (int c = 0; c < `NB_CORES; c++) begin
        m_mask[c] = '0;
        m_buf[c]  = '0;
      end
      m_en       = 1'b0;
      m_evt      = 1'b0;
      m_cnt      = 32'd0;
      m_cmp      = 32'd0;
      exp_rvalid = 1'b0;
    end else begin
      compare_outputs();
      step_model();
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

  //************************************************************
  // Stimulus
  //************************************************************
  task automatic put_request(input logic req, input logic [3:0] sel, input logic [1:0] off,
                             input logic wen, input logic [31:0] wdata);
    logic [31:0] fill;
    fill = rand32();
    periph_req_i   <= req;
    periph_add_i   <= {fill[31:12], sel, fill[7:4], off, 2'b00};
    periph_wen_i   <= wen;
    periph_wdata_i <= wdata;
    periph_id_i    <= fill[`PERIPH_ID_WIDTH-1:0];
  endtask

  task automatic quiet_events();
    dma_event_i   <= '0;
    dma_irq_i     <= '0;
    hwpe_events_i <= '0;
    irq_ack_i     <= '0;
  endtask

  task automatic bus_cycle(input logic [3:0] sel, input logic [1:0] off, input logic wen,
                           input logic [31:0] wdata);
    @(posedge clk_i);
    put_request(1'b1, sel, off, wen, wdata);
    quiet_events();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      put_request(1'b0, 4'd0, 2'd0, 1'b1, 32'd0);
      quiet_events();
    end
  endtask

  task automatic reg_rw_phase();
    test_name = "reg_rw";
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_cycle(4'(c), EU_MASK, 1'b0, rand32());
      bus_cycle(4'(c), EU_MASK, 1'b1, 32'd0);
    end
    bus_cycle(TGT_TIMER, TMR_CMP, 1'b0, rand32());
    bus_cycle(TGT_TIMER, TMR_CMP, 1'b1, 32'd0);
    bus_cycle(TGT_TIMER, TMR_CNT, 1'b0, rand32());
    bus_cycle(TGT_TIMER, TMR_CNT, 1'b1, 32'd0);
    bus_cycle(TGT_TIMER, TMR_CFG, 1'b0, rand32());
    bus_cycle(TGT_TIMER, TMR_CFG, 1'b1, 32'd0);
    bus_cycle(TGT_TIMER, TMR_CFG, 1'b0, 32'd0);
  endtask

  task automatic unmapped_phase();
    test_name = "unmapped";
    repeat (60) begin
      bus_cycle(4'(`NB_CORES + rand_below(15 - `NB_CORES)), 2'(rand_below(4)),
                1'(rand_below(2)), rand32());
    end
    // Nothing behind the unmapped range may have moved
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_cycle(4'(c), EU_MASK, 1'b1, 32'd0);
    end
    bus_cycle(TGT_TIMER, TMR_CMP, 1'b1, 32'd0);
  endtask

  task automatic sw_evt_phase();
    test_name = "sw_evt_w1c";
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_cycle(4'(c), EU_BUFFER, 1'b0, 32'hFF);
      bus_cycle(4'(c), EU_SW_EVT, 1'b0, rand32());
      // Hardware events fill the lower buffer bits for the clear below
      dma_event_i[c]   <= 1'b1;
      dma_irq_i[c]     <= 1'b1;
      hwpe_events_i[c] <= 4'hF;
      bus_cycle(4'(c), EU_BUFFER, 1'b1, 32'd0);
      bus_cycle(4'(c), EU_BUFFER, 1'b0, rand32() & 32'h7F);
      bus_cycle(4'(c), EU_BUFFER, 1'b1, 32'd0);
      bus_cycle(4'(c), EU_BUFFER, 1'b0, 32'h80);
      bus_cycle(4'(c), EU_BUFFER, 1'b1, 32'd0);
    end
  endtask

  // DMA event and acknowledge of the same bit in one cycle on core 0
  task automatic set_wins_phase();
    test_name = "set_wins";
    bus_cycle(4'd0, EU_MASK, 1'b0, 32'hFF);
    bus_cycle(4'd0, EU_BUFFER, 1'b0, 32'hFF);
    idle_cycles(1);
    dma_event_i[0] <= 1'b1;
    @(posedge clk_i);
    dma_event_i[0]  <= 1'b1;
    irq_ack_i[0]    <= 1'b1;
    irq_ack_id_i[0] <= EVT_DMA;
    bus_cycle(4'd0, EU_BUFFER, 1'b1, 32'd0);
    @(posedge clk_i);
    put_request(1'b0, 4'd0, 2'd0, 1'b1, 32'd0);
    irq_ack_i[0]    <= 1'b1;
    irq_ack_id_i[0] <= EVT_DMA;
    bus_cycle(4'd0, EU_BUFFER, 1'b1, 32'd0);
  endtask

  task automatic timer_phase();
    int   period;
    int   last_rise;
    logic prev_irq;
    test_name = "timer_period";
    period = 2 + rand_below(8);
    bus_cycle(TGT_TIMER, TMR_CFG, 1'b0, 32'd0);
    for (int c = 0; c < `NB_CORES; c++) begin
      bus_cycle(4'(c), EU_MASK, 1'b0, 32'h04);
      bus_cycle(4'(c), EU_BUFFER, 1'b0, 32'hFF);
    end
    bus_cycle(TGT_TIMER, TMR_CMP, 1'b0, 32'(period));
    bus_cycle(TGT_TIMER, TMR_CNT, 1'b0, 32'd0);
    bus_cycle(TGT_TIMER, TMR_CFG, 1'b0, 32'd1);
    last_rise = -1;
    prev_irq  = 1'b0;
    repeat (6 * (period + 1)) begin
      @(posedge clk_i);
      put_request(1'b0, 4'd0, 2'd0, 1'b1, 32'd0);
      for (int c = 0; c < `NB_CORES; c++) begin
        irq_ack_i[c]    <= |(m_buf[c] & m_mask[c]);
        irq_ack_id_i[c] <= EVT_TIMER;
      end
      @(negedge clk_i);
      // Acked at once, so each timer event is a one-cycle irq on core 0
      if (irq_req_o[0] && !prev_irq) begin
        if (last_rise >= 0) begin
          check_value("timer_period interval", 32'(period + 1), 32'(cycle_cnt - last_rise));
        end
        last_rise = cycle_cnt;
      end
      prev_irq = irq_req_o[0];
    end
    test_name = "timer_restart";
    bus_cycle(TGT_TIMER, TMR_CNT, 1'b0, 32'(rand_below(period)));
    repeat (3 * (period + 1)) begin
      @(posedge clk_i);
      put_request(1'b0, 4'd0, 2'd0, 1'b1, 32'd0);
      for (int c = 0; c < `NB_CORES; c++) begin
        irq_ack_i[c]    <= |(m_buf[c] & m_mask[c]);
        irq_ack_id_i[c] <= EVT_TIMER;
      end
    end
  endtask

  task automatic random_phase();
    logic [31:0] r;
    logic [31:0] ev;
    logic [31:0] d;
    logic [3:0]  sel;
    logic [1:0]  off;
    int          kind;
    test_name = "random";
    repeat (RANDOM_CYCLES) begin
      r    = rand32();
      kind = int'(r[3:1]);
      if (kind < 4) begin
        sel = 4'(rand_below(`NB_CORES));
      end else if (kind < 6) begin
        sel = TGT_TIMER;
      end else begin
        sel = 4'(`NB_CORES + rand_below(15 - `NB_CORES));
      end
      off = r[5:4];
      d   = rand32();
      // Small counter and compare values so the timer fires now and then
      if ((sel == TGT_TIMER) && ((off == TMR_CNT) || (off == TMR_CMP))) begin
        d = d & 32'hF;
      end
      // A zero compare value would fire the timer event every cycle
      if ((sel == TGT_TIMER) && (off == TMR_CMP) && (d == 32'd0)) begin
        d = 32'd1;
      end
      @(posedge clk_i);
      put_request(r[0], sel, off, r[6], d);
      for (int c = 0; c < `NB_CORES; c++) begin
        ev = rand32();
        dma_event_i[c]   <= &ev[2:0];
        dma_irq_i[c]     <= &ev[5:3];
        hwpe_events_i[c] <= ev[9:6] & ev[13:10] & ev[17:14];
        irq_ack_i[c]     <= ev[18] && (|(m_buf[c] & m_mask[c]));
        irq_ack_id_i[c]  <= (ev[20:19] == 2'd0) ? ev[23:21]
                                                 : lowest_pending(m_buf[c] & m_mask[c]);
      end
    end
  endtask

  initial begin
    rng_state      = 32'h3d2c433f;
    test_name      = "reset";
    reset_i        = 1'b1;
    periph_req_i   = 1'b0;
    periph_add_i   = 32'd0;
    periph_wen_i   = 1'b1;
    periph_wdata_i = 32'd0;
    periph_id_i    = '0;
    dma_event_i    = '0;
    dma_irq_i      = '0;
    hwpe_events_i  = '0;
    irq_ack_i      = '0;
    irq_ack_id_i   = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    reg_rw_phase();
    unmapped_phase();
    sw_evt_phase();
    set_wins_phase();
    timer_phase();
    random_phase();
    idle_cycles(3);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
